// ==== Bender.yml ====
package:
  name: rename

sources:
  - include_dirs:
      - .
    files:
      - regTypesPkg.sv
      - renamePktPkg.sv
      - SpecFreeList.sv
      - RenameMapTable.sv
      - RenameLane.sv
      - PipeReg.sv
      - Rename.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_Rename.sv

// ==== PipeReg.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module PipeReg #(
  parameter type T = regTypesPkg::physReg_t
) (
  input  logic clk,
  input  logic rstN_i,
  input  T     d_i     [0:`DISPATCH_WIDTH-1],
  input  logic valid_i [0:`DISPATCH_WIDTH-1],
  output T     q_o     [0:`DISPATCH_WIDTH-1]
);

  T     dataQ  [0:`DISPATCH_WIDTH-1];
  logic validQ [0:`DISPATCH_WIDTH-1];

  always_ff @(posedge clk)
  begin
    dataQ <= d_i;
  end

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
      validQ <= '{default: 1'b0};
    else
      validQ <= valid_i;
  end

  // payload as registered, valid from the reset flop
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      q_o[i]       = dataQ[i];
      q_o[i].valid = validQ[i];
    end
  end

endmodule

// ==== Rename.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module Rename (
  input  logic                  clk,
  input  logic                  rstN_i,
  input  logic                  stall_i,
  input  logic                  instBufferReady_i,
  input  renamePktPkg::renPkt_t renPacket_i   [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::physReg_t freedPhyReg_i [0:`COMMIT_WIDTH-1],
  input  logic                  repairFlag_i,
  input  regTypesPkg::logIdx_t  repairAddr_i  [0:`N_REPAIR_PACKETS-1],
  input  regTypesPkg::physIdx_t repairData_i  [0:`N_REPAIR_PACKETS-1],
  output renamePktPkg::disPkt_t disPacket_o   [0:`DISPATCH_WIDTH-1],
  output regTypesPkg::physReg_t phyDest_o     [0:`DISPATCH_WIDTH-1],
  output logic                  freeListEmpty_o,
  output logic                  renameReady_o
);
  import regTypesPkg::*;
  import renamePktPkg::*;

  logReg_t  logDest    [0:`DISPATCH_WIDTH-1];
  logReg_t  logSrc1    [0:`DISPATCH_WIDTH-1];
  logReg_t  logSrc2    [0:`DISPATCH_WIDTH-1];
  physReg_t rawSrc1    [0:`DISPATCH_WIDTH-1];
  physReg_t rawSrc2    [0:`DISPATCH_WIDTH-1];
  physIdx_t freePhyReg [0:`DISPATCH_WIDTH-1];
  logic     reqPhyReg  [0:`DISPATCH_WIDTH-1];
  disPkt_t  laneDis    [0:`DISPATCH_WIDTH-1];
  physReg_t laneDest   [0:`DISPATCH_WIDTH-1];
  logic     disValid   [0:`DISPATCH_WIDTH-1];
  logic     destValid  [0:`DISPATCH_WIDTH-1];

  always_comb
  begin
    renameReady_o = instBufferReady_i & ~freeListEmpty_o & ~stall_i;
  end

  // split packet fields for the table, request a register per renamed dest
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      logDest[i].regId = renPacket_i[i].logDest;
      logDest[i].valid = renPacket_i[i].valid & renPacket_i[i].logDestValid;
      logSrc1[i].regId = renPacket_i[i].logSrc1;
      logSrc1[i].valid = renPacket_i[i].logSrc1Valid;
      logSrc2[i].regId = renPacket_i[i].logSrc2;
      logSrc2[i].valid = renPacket_i[i].logSrc2Valid;
      reqPhyReg[i]     = logDest[i].valid & renameReady_o;
      disValid[i]      = laneDis[i].valid;
      destValid[i]     = laneDest[i].valid;
    end
  end

  SpecFreeList specFreeList (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .reqPhyReg_i     (reqPhyReg),
    .freedPhyReg_i   (freedPhyReg_i),
    .freePhyReg_o    (freePhyReg),
    .freeListEmpty_o (freeListEmpty_o)
  );

  // table is written only when the group advances
  RenameMapTable rmt (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .stall_i      (~renameReady_o),
    .logSrc1_i    (logSrc1),
    .logSrc2_i    (logSrc2),
    .logDest_i    (logDest),
    .newPhys_i    (freePhyReg),
    .repairFlag_i (repairFlag_i),
    .repairAddr_i (repairAddr_i),
    .repairData_i (repairData_i),
    .rawSrc1_o    (rawSrc1),
    .rawSrc2_o    (rawSrc2)
  );

  for (genvar i = 0; i < `DISPATCH_WIDTH; i++)
  begin : genLane
    RenameLane #(.LANE(i)) renameLane (
      .renPacket_i (renPacket_i[i]),
      .rawSrc1_i   (rawSrc1[i]),
      .rawSrc2_i   (rawSrc2[i]),
      .groupDest_i (logDest),
      .groupPhys_i (freePhyReg),
      .laneReady_i (renameReady_o),
      .disPacket_o (laneDis[i]),
      .phyDest_o   (laneDest[i])
    );
  end

  PipeReg #(.T(disPkt_t)) disPacketReg (
    .clk     (clk),
    .rstN_i  (rstN_i),
    .d_i     (laneDis),
    .valid_i (disValid),
    .q_o     (disPacket_o)
  );

  // destinations go on to the scoreboard to be marked not ready
  PipeReg #(.T(physReg_t)) phyDestReg (
    .clk     (clk),
    .rstN_i  (rstN_i),
    .d_i     (laneDest),
    .valid_i (destValid),
    .q_o     (phyDest_o)
  );

endmodule

// ==== RenameLane.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module RenameLane #(
  parameter int LANE = 0
) (
  input  renamePktPkg::renPkt_t renPacket_i,
  input  regTypesPkg::physReg_t rawSrc1_i,
  input  regTypesPkg::physReg_t rawSrc2_i,
  input  regTypesPkg::logReg_t  groupDest_i [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::physIdx_t groupPhys_i [0:`DISPATCH_WIDTH-1],
  input  logic                  laneReady_i,
  output renamePktPkg::disPkt_t disPacket_o,
  output regTypesPkg::physReg_t phyDest_o
);
  import regTypesPkg::*;

  physReg_t phySrc1;
  physReg_t phySrc2;
  logic     destValid;

  // older lanes in the group override the table, youngest match last
  always_comb
  begin
    phySrc1 = rawSrc1_i;
    phySrc2 = rawSrc2_i;
    for (int j = 0; j < LANE; j++)
    begin
      if (groupDest_i[j].valid && (groupDest_i[j].regId == renPacket_i.logSrc1))
        phySrc1.regId = groupPhys_i[j];
      if (groupDest_i[j].valid && (groupDest_i[j].regId == renPacket_i.logSrc2))
        phySrc2.regId = groupPhys_i[j];
    end
  end

  always_comb
  begin
    destValid       = renPacket_i.valid & renPacket_i.logDestValid;
    phyDest_o.regId = groupPhys_i[LANE];
    phyDest_o.valid = destValid & laneReady_i;

    disPacket_o.valid        = renPacket_i.valid & laneReady_i;
    disPacket_o.seqNo        = renPacket_i.seqNo;
    disPacket_o.pc           = renPacket_i.pc;
    disPacket_o.logDest      = renPacket_i.logDest;
    disPacket_o.phyDest      = groupPhys_i[LANE];
    disPacket_o.phyDestValid = destValid;
    disPacket_o.phySrc1      = phySrc1.regId;
    disPacket_o.phySrc1Valid = phySrc1.valid;
    disPacket_o.phySrc2      = phySrc2.regId;
    disPacket_o.phySrc2Valid = phySrc2.valid;
  end

  // new register must not be handed to an older lane as well
  always_comb
  begin
    if (phyDest_o.valid)
    begin
      for (int j = 0; j < LANE; j++)
      begin
        assert #0 (!groupDest_i[j].valid || (groupPhys_i[j] != phyDest_o.regId))
          else $error("lane %0d and lane %0d share phyDest 0x%h", LANE, j, phyDest_o.regId);
      end
    end
  end

endmodule

// ==== RenameMapTable.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module RenameMapTable (
  input  logic                  clk,
  input  logic                  rstN_i,
  input  logic                  stall_i,
  input  regTypesPkg::logReg_t  logSrc1_i    [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::logReg_t  logSrc2_i    [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::logReg_t  logDest_i    [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::physIdx_t newPhys_i    [0:`DISPATCH_WIDTH-1],
  input  logic                  repairFlag_i,
  input  regTypesPkg::logIdx_t  repairAddr_i [0:`N_REPAIR_PACKETS-1],
  input  regTypesPkg::physIdx_t repairData_i [0:`N_REPAIR_PACKETS-1],
  output regTypesPkg::physReg_t rawSrc1_o    [0:`DISPATCH_WIDTH-1],
  output regTypesPkg::physReg_t rawSrc2_o    [0:`DISPATCH_WIDTH-1]
);
  import regTypesPkg::*;

  // speculative logical to physical map
  physIdx_t mapTable [0:`NUM_LOG_REGS-1];

  // sources see the table as it stood before this group
  always_comb
  begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      rawSrc1_o[i].regId = mapTable[logSrc1_i[i].regId];
      rawSrc1_o[i].valid = logSrc1_i[i].valid;
      rawSrc2_o[i].regId = mapTable[logSrc2_i[i].regId];
      rawSrc2_o[i].valid = logSrc2_i[i].valid;
    end
  end

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      // identity map out of reset
      for (int r = 0; r < `NUM_LOG_REGS; r++)
      begin
        mapTable[r] <= physIdx_t'(r);
      end
    end
    else
    begin
      // lanes written oldest first so the youngest writer of an entry stays
      if (!stall_i)
      begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++)
        begin
          if (logDest_i[i].valid)
          begin
            mapTable[logDest_i[i].regId] <= newPhys_i[i];
          end
        end
      end

      // repair comes last and overrides any rename write to the same entry
      if (repairFlag_i)
      begin
        for (int p = 0; p < `N_REPAIR_PACKETS; p++)
        begin
          mapTable[repairAddr_i[p]] <= repairData_i[p];
        end
      end
    end
  end

endmodule

// ==== SpecFreeList.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module SpecFreeList (
  input  logic                  clk,
  input  logic                  rstN_i,
  input  logic                  reqPhyReg_i   [0:`DISPATCH_WIDTH-1],
  input  regTypesPkg::physReg_t freedPhyReg_i [0:`COMMIT_WIDTH-1],
  output regTypesPkg::physIdx_t freePhyReg_o  [0:`DISPATCH_WIDTH-1],
  output logic                  freeListEmpty_o
);
  import regTypesPkg::*;

  typedef logic [`SIZE_FREE_LIST_LOG-1:0] ptr_t;
  typedef logic [`SIZE_FREE_LIST_LOG:0]   cnt_t;

  physIdx_t freeList   [0:`SIZE_FREE_LIST-1];
  ptr_t     headPtr;
  ptr_t     tailPtr;
  cnt_t     freeCnt;
  ptr_t     popOffset  [0:`DISPATCH_WIDTH-1];
  ptr_t     pushOffset [0:`COMMIT_WIDTH-1];
  cnt_t     numPop;
  cnt_t     numPush;

  // k-th requesting lane takes the k-th entry from the head
  always_comb
  begin
    numPop = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++)
    begin
      popOffset[i]    = numPop[`SIZE_FREE_LIST_LOG-1:0];
      freePhyReg_o[i] = freeList[headPtr + popOffset[i]];
      numPop          = numPop + {{`SIZE_FREE_LIST_LOG{1'b0}}, reqPhyReg_i[i]};
    end
  end

  // freed registers are packed behind the tail in commit-lane order
  always_comb
  begin
    numPush = '0;
    for (int j = 0; j < `COMMIT_WIDTH; j++)
    begin
      pushOffset[j] = numPush[`SIZE_FREE_LIST_LOG-1:0];
      numPush       = numPush + {{`SIZE_FREE_LIST_LOG{1'b0}}, freedPhyReg_i[j].valid};
    end
  end

  // keep a full group's worth in reserve
  always_comb
  begin
    freeListEmpty_o = (freeCnt < cnt_t'(`DISPATCH_WIDTH));
  end

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      // registers above the architectural range start out free
      for (int k = 0; k < `SIZE_FREE_LIST; k++)
      begin
        freeList[k] <= physIdx_t'(`NUM_LOG_REGS + k);
      end
      headPtr <= '0;
      tailPtr <= '0;
      freeCnt <= cnt_t'(`SIZE_FREE_LIST);
    end
    else
    begin
      for (int j = 0; j < `COMMIT_WIDTH; j++)
      begin
        if (freedPhyReg_i[j].valid)
        begin
          freeList[tailPtr + pushOffset[j]] <= freedPhyReg_i[j].regId;
        end
      end
      headPtr <= headPtr + numPop[`SIZE_FREE_LIST_LOG-1:0];
      tailPtr <= tailPtr + numPush[`SIZE_FREE_LIST_LOG-1:0];
      freeCnt <= freeCnt + numPush - numPop;
    end
  end

  // more frees than allocations would mean a register was freed twice
  countBoundChk: assert property (
    @(posedge clk) disable iff (!rstN_i)
    freeCnt <= cnt_t'(`SIZE_FREE_LIST)
  ) else $error("free list count %0d above depth", freeCnt);

  // the top level must hold off requests while the reserve is short
  popWhileEmptyChk: assert property (
    @(posedge clk) disable iff (!rstN_i)
    (numPop != '0) |-> !freeListEmpty_o
  ) else $error("free list popped while empty, count %0d", freeCnt);

endmodule

// ==== compile.f ====
+incdir+.
regTypesPkg.sv
renamePktPkg.sv
SpecFreeList.sv
RenameMapTable.sv
RenameLane.sv
PipeReg.sv
Rename.sv
tb_Rename.sv

// ==== regTypesPkg.sv ====
`include "rename_config.svh"

package regTypesPkg;

  // bare register indices
  typedef logic [`SIZE_LOG_LOG-1:0]      logIdx_t;
  typedef logic [`SIZE_PHYSICAL_LOG-1:0] physIdx_t;

  // logical register with its valid bit
  typedef struct packed {
    logIdx_t  regId;
    logic     valid;
  } logReg_t;

  // physical register with its valid bit
  typedef struct packed {
    physIdx_t regId;
    logic     valid;
  } physReg_t;

endpackage

// ==== renamePktPkg.sv ====
`include "rename_config.svh"

package renamePktPkg;
  import regTypesPkg::*;

  // decoded instruction as it enters rename
  typedef struct packed {
    logic                  valid;
    logic [`SEQ_WIDTH-1:0] seqNo;
    logic [`PC_WIDTH-1:0]  pc;
    logIdx_t               logDest;
    logic                  logDestValid;
    logIdx_t               logSrc1;
    logic                  logSrc1Valid;
    logIdx_t               logSrc2;
    logic                  logSrc2Valid;
  } renPkt_t;

  // renamed instruction handed to dispatch
  typedef struct packed {
    logic                  valid;
    logic [`SEQ_WIDTH-1:0] seqNo;
    logic [`PC_WIDTH-1:0]  pc;
    logIdx_t               logDest;
    physIdx_t              phyDest;
    logic                  phyDestValid;
    physIdx_t              phySrc1;
    logic                  phySrc1Valid;
    physIdx_t              phySrc2;
    logic                  phySrc2Valid;
  } disPkt_t;

endpackage

// ==== rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// group sizes
`define DISPATCH_WIDTH      2
`define COMMIT_WIDTH        2
`define N_REPAIR_PACKETS    2

// logical register file
`define NUM_LOG_REGS        16
`define SIZE_LOG_LOG        4

// physical register file
`define NUM_PHY_REGS        32
`define SIZE_PHYSICAL_LOG   5

// registers not holding an architectural value at reset
`define SIZE_FREE_LIST      16
`define SIZE_FREE_LIST_LOG  4

// instruction fields carried through rename
`define PC_WIDTH            32
`define SEQ_WIDTH           8

`endif

// ==== tb_Rename.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module tb_Rename;
  import regTypesPkg::*;
  import renamePktPkg::*;

  // cycles per test, the run is cut off at twice their sum
  localparam int TEST_CYCLES = 16 + 3 + 3 + 200 + 40 + 10 + 8 + 6 * 2;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic     clk;
  logic     rstN_i;
  logic     stall_i;
  logic     instBufferReady_i;
  renPkt_t  renPacket_i   [0:`DISPATCH_WIDTH-1];
  physReg_t freedPhyReg_i [0:`COMMIT_WIDTH-1];
  logic     repairFlag_i;
  logIdx_t  repairAddr_i  [0:`N_REPAIR_PACKETS-1];
  physIdx_t repairData_i  [0:`N_REPAIR_PACKETS-1];
  disPkt_t  disPacket_o   [0:`DISPATCH_WIDTH-1];
  physReg_t phyDest_o     [0:`DISPATCH_WIDTH-1];
  logic     freeListEmpty_o;
  logic     renameReady_o;

  // reference model state
  physIdx_t mapM    [0:`NUM_LOG_REGS-1];
  physIdx_t freeQ   [$];
  physIdx_t retireQ [$];
  int       freeCount;
  disPkt_t  expDis  [0:`DISPATCH_WIDTH-1];
  physReg_t expDest [0:`DISPATCH_WIDTH-1];

  int errCount    = 0;
  int testErrBase = 0;
  int testsRun    = 0;
  int testsFailed = 0;
  int seqCounter  = 0;
  int cycleCount  = 0;

  Rename Rename_inst (
    .clk               (clk),
    .rstN_i            (rstN_i),
    .stall_i           (stall_i),
    .instBufferReady_i (instBufferReady_i),
    .renPacket_i       (renPacket_i),
    .freedPhyReg_i     (freedPhyReg_i),
    .repairFlag_i      (repairFlag_i),
    .repairAddr_i      (repairAddr_i),
    .repairData_i      (repairData_i),
    .disPacket_o       (disPacket_o),
    .phyDest_o         (phyDest_o),
    .freeListEmpty_o   (freeListEmpty_o),
    .renameReady_o     (renameReady_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // model advances at every edge, expected outputs show up one edge later
  always @(posedge clk)
  begin : refModel
    logic     accept;
    logic     wrDest  [0:`DISPATCH_WIDTH-1];
    physIdx_t newPhys [0:`DISPATCH_WIDTH-1];
    disPkt_t  nextDis;
    physReg_t nextDest;
    if (!rstN_i)
    begin
      for (int r = 0; r < `NUM_LOG_REGS; r++)
        mapM[r] = physIdx_t'(r);
      freeQ.delete();
      retireQ.delete();
      for (int k = 0; k < `SIZE_FREE_LIST; k++)
        freeQ.push_back(physIdx_t'(`NUM_LOG_REGS + k));
      for (int i = 0; i < `DISPATCH_WIDTH; i++)
      begin
        expDis[i]  <= '0;
        expDest[i] <= '0;
      end
    end
    else
    begin
      accept = instBufferReady_i && !stall_i && (freeQ.size() >= `DISPATCH_WIDTH);
      for (int i = 0; i < `DISPATCH_WIDTH; i++)
      begin
        wrDest[i]  = renPacket_i[i].valid && renPacket_i[i].logDestValid;
        newPhys[i] = '0;
        if (accept && wrDest[i])
          newPhys[i] = freeQ.pop_front();
      end
      for (int i = 0; i < `DISPATCH_WIDTH; i++)
      begin
        nextDis              = '0;
        nextDis.valid        = renPacket_i[i].valid && accept;
        nextDis.seqNo        = renPacket_i[i].seqNo;
        nextDis.pc           = renPacket_i[i].pc;
        nextDis.logDest      = renPacket_i[i].logDest;
        nextDis.phyDest      = newPhys[i];
        nextDis.phyDestValid = wrDest[i];
        nextDis.phySrc1      = mapM[renPacket_i[i].logSrc1];
        nextDis.phySrc1Valid = renPacket_i[i].logSrc1Valid;
        nextDis.phySrc2      = mapM[renPacket_i[i].logSrc2];
        nextDis.phySrc2Valid = renPacket_i[i].logSrc2Valid;
        // youngest older writer of the same register wins
        for (int j = 0; j < i; j++)
        begin
          if (wrDest[j] && renPacket_i[j].logDest == renPacket_i[i].logSrc1)
            nextDis.phySrc1 = newPhys[j];
          if (wrDest[j] && renPacket_i[j].logDest == renPacket_i[i].logSrc2)
            nextDis.phySrc2 = newPhys[j];
        end
        nextDest.regId = newPhys[i];
        nextDest.valid = wrDest[i] && accept;
        expDis[i]  <= nextDis;
        expDest[i] <= nextDest;
      end
      // displaced mappings become candidates for later frees
      for (int i = 0; i < `DISPATCH_WIDTH; i++)
      begin
        if (accept && wrDest[i])
        begin
          retireQ.push_back(mapM[renPacket_i[i].logDest]);
          mapM[renPacket_i[i].logDest] = newPhys[i];
        end
      end
      for (int c = 0; c < `COMMIT_WIDTH; c++)
      begin
        if (freedPhyReg_i[c].valid)
          freeQ.push_back(freedPhyReg_i[c].regId);
      end
      if (repairFlag_i)
      begin
        for (int p = 0; p < `N_REPAIR_PACKETS; p++)
        begin
          retireQ.push_back(mapM[repairAddr_i[p]]);
          mapM[repairAddr_i[p]] = repairData_i[p];
        end
      end
    end
    freeCount = freeQ.size();
  end

  readyChk: assert property (@(posedge clk) disable iff (!rstN_i)
    renameReady_o == (instBufferReady_i && !stall_i && freeCount >= `DISPATCH_WIDTH))
  else
  begin
    errCount++;
    $display("ERROR: renameReady_o got 0x%h expected 0x%h, free count %0d",
             $sampled(renameReady_o),
             $sampled(instBufferReady_i && !stall_i && freeCount >= `DISPATCH_WIDTH),
             $sampled(freeCount));
  end

  emptyChk: assert property (@(posedge clk) disable iff (!rstN_i)
    freeListEmpty_o == (freeCount < `DISPATCH_WIDTH))
  else
  begin
    errCount++;
    $display("ERROR: freeListEmpty_o got 0x%h expected 0x%h, free count %0d",
             $sampled(freeListEmpty_o), $sampled(freeCount < `DISPATCH_WIDTH),
             $sampled(freeCount));
  end

  for (genvar i = 0; i < `DISPATCH_WIDTH; i++)
  begin : genLaneChk
    logic [`SEQ_WIDTH+`PC_WIDTH+`SIZE_LOG_LOG:0] gotInfo;
    logic [`SEQ_WIDTH+`PC_WIDTH+`SIZE_LOG_LOG:0] wantInfo;
    logic [2*`SIZE_PHYSICAL_LOG+1:0]              gotSrc;
    logic [2*`SIZE_PHYSICAL_LOG+1:0]              wantSrc;

    assign gotInfo  = {disPacket_o[i].seqNo, disPacket_o[i].pc, disPacket_o[i].logDest,
                       disPacket_o[i].phyDestValid};
    assign wantInfo = {expDis[i].seqNo, expDis[i].pc, expDis[i].logDest,
                       expDis[i].phyDestValid};
    assign gotSrc   = {disPacket_o[i].phySrc1, disPacket_o[i].phySrc1Valid,
                       disPacket_o[i].phySrc2, disPacket_o[i].phySrc2Valid};
    assign wantSrc  = {expDis[i].phySrc1, expDis[i].phySrc1Valid,
                       expDis[i].phySrc2, expDis[i].phySrc2Valid};

    validChk: assert property (@(posedge clk) disable iff (!rstN_i)
      {disPacket_o[i].valid, phyDest_o[i].valid} == {expDis[i].valid, expDest[i].valid})
    else
    begin
      errCount++;
      $display("ERROR: disPacket_o[%0d].valid/phyDest_o.valid got 0x%h expected 0x%h", i,
               $sampled({disPacket_o[i].valid, phyDest_o[i].valid}),
               $sampled({expDis[i].valid, expDest[i].valid}));
    end

    infoChk: assert property (@(posedge clk) disable iff (!rstN_i)
      expDis[i].valid |-> gotInfo == wantInfo)
    else
    begin
      errCount++;
      $display("ERROR: disPacket_o[%0d] seqNo/pc/logDest got 0x%h expected 0x%h", i,
               $sampled(gotInfo), $sampled(wantInfo));
    end

    srcChk: assert property (@(posedge clk) disable iff (!rstN_i)
      expDis[i].valid |-> gotSrc == wantSrc)
    else
    begin
      errCount++;
      $display("ERROR: disPacket_o[%0d] phySrc1/phySrc2 got 0x%h expected 0x%h", i,
               $sampled(gotSrc), $sampled(wantSrc));
    end

    destChk: assert property (@(posedge clk) disable iff (!rstN_i)
      expDest[i].valid |-> (phyDest_o[i].regId == expDest[i].regId)
                           && (disPacket_o[i].phyDest == expDest[i].regId))
    else
    begin
      errCount++;
      $display("ERROR: phyDest_o[%0d].regId/disPacket_o.phyDest got 0x%h/0x%h expected 0x%h",
               i, $sampled(phyDest_o[i].regId), $sampled(disPacket_o[i].phyDest),
               $sampled(expDest[i].regId));
    end
  end

  // dest below zero means the instruction writes no register
  function automatic renPkt_t buildPkt(input int dest, input int src1, input int src2);
    renPkt_t p;
    p              = '0;
    p.valid        = 1'b1;
    p.seqNo        = seqCounter[`SEQ_WIDTH-1:0];
    p.pc           = `PC_WIDTH'(32'h0000_1000 + 4 * seqCounter);
    p.logDestValid = (dest >= 0);
    p.logDest      = logIdx_t'((dest < 0) ? 0 : dest);
    p.logSrc1      = logIdx_t'(src1);
    p.logSrc1Valid = 1'b1;
    p.logSrc2      = logIdx_t'(src2);
    p.logSrc2Valid = 1'b1;
    seqCounter++;
    return p;
  endfunction

  // small register range so lanes collide often
  function automatic renPkt_t randomPkt();
    renPkt_t p;
    p              = buildPkt($urandom % 8, $urandom % 8, $urandom % 8);
    p.valid        = ($urandom % 4) != 0;
    p.logDestValid = ($urandom % 3) != 0;
    p.logSrc1Valid = $urandom % 2;
    p.logSrc2Valid = $urandom % 2;
    return p;
  endfunction

  task automatic driveCycle(input renPkt_t p0, input renPkt_t p1, input int nFree,
                            input logic stallIn, input logic bufReady);
    @(negedge clk);
    renPacket_i[0] = p0;
    renPacket_i[1] = p1;
    for (int c = 0; c < `COMMIT_WIDTH; c++)
    begin
      freedPhyReg_i[c] = '0;
      if (c < nFree && retireQ.size() > 0)
      begin
        freedPhyReg_i[c].regId = retireQ.pop_front();
        freedPhyReg_i[c].valid = 1'b1;
      end
    end
    stall_i           = stallIn;
    instBufferReady_i = bufReady;
    repairFlag_i      = 1'b0;
  endtask

  // one idle cycle lets the last group's checks fire
  task automatic endTest(input string name);
    driveCycle('0, '0, 0, 1'b0, 1'b1);
    @(negedge clk);
    testsRun++;
    if (errCount != testErrBase)
    begin
      testsFailed++;
      $display("test %s: failed with %0d errors", name, errCount - testErrBase);
    end
    else
      $display("test %s: ok", name);
    testErrBase = errCount;
  endtask

  initial
  begin
    renPkt_t g0;
    renPkt_t g1;
    int      n;
    void'($urandom(32'h9a7ab61f));
    rstN_i            = 1'b0;
    stall_i           = 1'b0;
    instBufferReady_i = 1'b1;
    repairFlag_i      = 1'b0;
    renPacket_i       = '{default: '0};
    freedPhyReg_i     = '{default: '0};
    repairAddr_i      = '{default: '0};
    repairData_i      = '{default: '0};
    repeat (16) @(negedge clk);
    rstN_i = 1'b1;

    driveCycle(buildPkt(1, 2, 3), buildPkt(4, 5, 6), 0, 1'b0, 1'b1);
    endTest("first group after reset");

    driveCycle(buildPkt(7, 1, 2), buildPkt(8, 7, 7), 0, 1'b0, 1'b1);
    driveCycle(buildPkt(7, 7, 8), buildPkt(7, 7, 3), 0, 1'b0, 1'b1);
    driveCycle(buildPkt(9, 7, 8), buildPkt(-1, 9, 7), 0, 1'b0, 1'b1);
    endTest("intra-group dependency");

    repeat (200)
      driveCycle(randomPkt(), randomPkt(), $urandom % 3, 1'b0, ($urandom % 8) != 0);
    endTest("random traffic");

    // drain the free list with no frees coming back
    n = 0;
    while (!freeListEmpty_o && n < 20)
    begin
      driveCycle(buildPkt(n % 16, 1, 2), buildPkt((n + 3) % 16, 3, 4), 0, 1'b0, 1'b1);
      n++;
    end
    if (!freeListEmpty_o)
    begin
      errCount++;
      $display("exhaustion: free list never reported empty after %0d groups", n);
    end
    repeat (2)
      driveCycle(buildPkt(3, 1, 2), buildPkt(4, 3, 3), 0, 1'b0, 1'b1);
    repeat (4)
      driveCycle(buildPkt(5, 4, 3), buildPkt(-1, 5, 4), 2, 1'b0, 1'b1);
    endTest("exhaustion and refill");

    g0 = buildPkt(6, 5, 4);
    g1 = buildPkt(2, 6, 1);
    repeat (3)
      driveCycle(g0, g1, 1, 1'b1, 1'b1);
    repeat (2)
      driveCycle(g0, g1, 1, 1'b0, 1'b0);
    driveCycle(g0, g1, 0, 1'b0, 1'b1);
    driveCycle(buildPkt(11, 6, 2), buildPkt(12, 2, 6), 0, 1'b0, 1'b1);
    endTest("stall");

    driveCycle(buildPkt(5, 1, 2), buildPkt(9, 3, 4), 0, 1'b0, 1'b1);
    driveCycle(buildPkt(5, 5, 9), buildPkt(10, 5, 9), 0, 1'b0, 1'b1);
    // repair r5 and r9 while lane 0 renames r5 in the same cycle
    repairFlag_i    = 1'b1;
    repairAddr_i[0] = logIdx_t'(5);
    repairData_i[0] = retireQ.pop_front();
    repairAddr_i[1] = logIdx_t'(9);
    repairData_i[1] = retireQ.pop_front();
    driveCycle(buildPkt(11, 5, 9), buildPkt(12, 9, 5), 0, 1'b0, 1'b1);
    driveCycle(buildPkt(13, 5, 9), buildPkt(14, 11, 12), 0, 1'b0, 1'b1);
    endTest("repair");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             testsRun, testsFailed, errCount);
    if (testsFailed == 0 && errCount == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
